// File: filelist.f
+incdir+include
verilog/scan_pkg.sv
verilog/video_stage_if.sv
verilog/timing_gen.sv
verilog/window_mask.sv
verilog/scanline_gen.sv
verilog/pixel_output.sv
verilog/scanconverter.sv
test/tb_scanconverter.sv

// File: test/scan_trace.txt
# h_total h_active h_sync h_bp v_total v_active v_sync v_bp x_off x_size y_off y_size period
# overlay(hex) strength(hex) testpattern mask_br mask_color frames de_cnt hsync_low vsync_low
40 24 4 6 12 6 2 2 0 24 0 6 0 00 000000 0 0 0 2 144 48 80
40 24 4 6 12 6 2 2 0 24 0 6 2 05 000312 0 0 0 1 144 48 80
36 20 3 5 14 8 3 2 4 10 2 3 5 2a f0a5c3 0 10 5 2 160 42 108
40 24 4 6 12 6 2 2 6 12 1 4 0 00 000000 0 12 3 1 144 48 80
32 16 2 4 10 5 1 2 2 8 1 2 3 3f ffffff 1 3 7 1 80 20 32
40 24 4 6 12 6 2 2 0 24 0 6 0 01 00000f 0 0 0 1 144 48 80

// File: include/tb_compare.svh
// Compare and report helpers for the testbench, included after scan_pkg is imported
// Any failure ends the run through $fatal
`ifndef TB_COMPARE_SVH
`define TB_COMPARE_SVH

// Closes a failed run
task automatic sim_fail();
    $display("Simulation failed");
    $fatal(1);
endtask

// Failures that are not a value mismatch, such as a timeout
task automatic report_failure(input string msg);
    $display("%s", msg);
    sim_fail();
endtask

task automatic compare_pixel(input pixel_t got, input pixel_t exp, input string what);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        sim_fail();
    end
endtask

task automatic compare_pos(input hcnt_t got_x, input vcnt_t got_y,
                           input hcnt_t exp_x, input vcnt_t exp_y);
    if ((got_x !== exp_x) || (got_y !== exp_y)) begin
        $display("MISMATCH at %0t: position got (%0d,%0d) expected (%0d,%0d)",
                 $time, got_x, got_y, exp_x, exp_y);
        sim_fail();
    end
endtask

task automatic compare_count(input integer got, input integer exp, input string what);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        sim_fail();
    end
endtask

// Galois LFSR for x^32+x^22+x^2+x+1
// The output bit is bit 0 of the state before the step
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

`endif

// File: test/tb_scanconverter.sv
// Trace-driven testbench for the scan converter, reading test/scan_trace.txt
// Every raster in the trace needs a front porch so no active pixel is in flight at a restart
`timescale 1ns/1ps

module tb_scanconverter
    import scan_pkg::*;
();

    `include "tb_compare.svh"

    localparam int MAX_REC = 16;
    localparam int N_COL   = 22;

    // Expected state of the outputs for one cycle, with frame bookkeeping
    typedef struct packed {
        logic       hs;
        logic       vs;
        logic       de;
        hcnt_t      x;
        vcnt_t      y;
        pixel_t     pix;
        logic       cnt_en;
        logic       last;
        logic [7:0] rec;
    } exp_t;

    logic                  PCLK_OUT_i;
    logic                  arst_n_i;
    logic                  frame_start_i;
    logic [7:0]            ext_r_i;
    logic [7:0]            ext_g_i;
    logic [7:0]            ext_b_i;
    hcnt_t                 h_total_i;
    hcnt_t                 h_active_i;
    hcnt_t                 h_synclen_i;
    hcnt_t                 h_backporch_i;
    vcnt_t                 v_total_i;
    vcnt_t                 v_active_i;
    vcnt_t                 v_synclen_i;
    vcnt_t                 v_backporch_i;
    hcnt_t                 x_offset_i;
    hcnt_t                 x_size_i;
    vcnt_t                 y_offset_i;
    vcnt_t                 y_size_i;
    sl_phase_t             sl_period_i;
    logic [SL_ROWS-1:0]    sl_overlay_i;
    sl_str_t [SL_ROWS-1:0] sl_strength_i;
    logic                  testpattern_en_i;
    logic [3:0]            mask_br_i;
    logic [2:0]            mask_color_i;
    logic [7:0]            r_o;
    logic [7:0]            g_o;
    logic [7:0]            b_o;
    logic                  hsync_o;
    logic                  vsync_o;
    logic                  de_o;
    hcnt_t                 xpos_o;
    vcnt_t                 ypos_o;

    // Columns 0-17 configure the DUT, 18 frames, 19-21 expected DE, HSYNC-low, VSYNC-low
    integer      cfg [0:MAX_REC-1][0:N_COL-1];
    integer      n_rec;
    integer      total_frames;
    integer      frames_done;
    integer      cycle_limit;
    integer      cycle_cnt;
    integer      acc_de;
    integer      acc_hs;
    integer      acc_vs;
    logic [31:0] lfsr_state;
    exp_t        exp_q[$];
    hcnt_t       m_h;
    vcnt_t       m_v;
    logic        m_run;
    integer      m_rec;

    scanconverter scanconverter_i (.*);

    initial begin
        PCLK_OUT_i = 1'b0;
        forever #50 PCLK_OUT_i = ~PCLK_OUT_i;
    end

    task automatic load_trace();
        integer fd;
        integer got;
        string  line;
        fd = $fopen("test/scan_trace.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open the trace file test/scan_trace.txt");
        end
        n_rec = 0;
        while (!$feof(fd) && n_rec < MAX_REC) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 1 && line.getc(0) != "#") begin
                got = $sscanf(line,
                    "%d %d %d %d %d %d %d %d %d %d %d %d %d %h %h %d %d %d %d %d %d %d",
                    cfg[n_rec][0], cfg[n_rec][1], cfg[n_rec][2], cfg[n_rec][3],
                    cfg[n_rec][4], cfg[n_rec][5], cfg[n_rec][6], cfg[n_rec][7],
                    cfg[n_rec][8], cfg[n_rec][9], cfg[n_rec][10], cfg[n_rec][11],
                    cfg[n_rec][12], cfg[n_rec][13], cfg[n_rec][14], cfg[n_rec][15],
                    cfg[n_rec][16], cfg[n_rec][17], cfg[n_rec][18], cfg[n_rec][19],
                    cfg[n_rec][20], cfg[n_rec][21]);
                if (got != N_COL) begin
                    report_failure("A trace line does not hold the expected number of columns");
                end
                n_rec++;
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_config(input integer r);
        h_total_i        <= cfg[r][0];
        h_active_i       <= cfg[r][1];
        h_synclen_i      <= cfg[r][2];
        h_backporch_i    <= cfg[r][3];
        v_total_i        <= cfg[r][4];
        v_active_i       <= cfg[r][5];
        v_synclen_i      <= cfg[r][6];
        v_backporch_i    <= cfg[r][7];
        x_offset_i       <= cfg[r][8];
        x_size_i         <= cfg[r][9];
        y_offset_i       <= cfg[r][10];
        y_size_i         <= cfg[r][11];
        sl_period_i      <= cfg[r][12];
        sl_overlay_i     <= cfg[r][13];
        sl_strength_i    <= cfg[r][14];
        testpattern_en_i <= cfg[r][15];
        mask_br_i        <= cfg[r][16];
        mask_color_i     <= cfg[r][17];
    endtask

    task automatic take_byte(output logic [7:0] val);
        for (int i = 0; i < 8; i++) begin
            val[i]     = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Test pattern first, then the mask colour, then scanlines on the source pixel
    function automatic pixel_t expect_pixel(input hcnt_t x, input vcnt_t y, input pixel_t src);
        pixel_t     p;
        integer     ph;
        integer     amount;
        integer     x_end;
        integer     y_end;
        logic [7:0] mv;
        p      = src;
        mv     = {mask_br_i, mask_br_i};
        ph     = y % (sl_period_i + 1);
        amount = (sl_strength_i[ph] + 1) * 16 - 1;
        x_end  = x_offset_i + x_size_i;
        y_end  = y_offset_i + y_size_i;
        if (testpattern_en_i) begin
            p = {3{x[7:0] ^ y[7:0]}};
        end else if (x < x_offset_i || x >= x_end || y < y_offset_i || y >= y_end) begin
            p.r = mask_color_i[2] ? mv : 8'd0;
            p.g = mask_color_i[1] ? mv : 8'd0;
            p.b = mask_color_i[0] ? mv : 8'd0;
        end else if (sl_overlay_i[ph]) begin
            p.r = (src.r > amount) ? src.r - amount : 8'd0;
            p.g = (src.g > amount) ? src.g - amount : 8'd0;
            p.b = (src.b > amount) ? src.b - amount : 8'd0;
        end
        return p;
    endfunction

    task automatic check_output(input exp_t o);
        compare_count(hsync_o, o.hs, "hsync");
        compare_count(vsync_o, o.vs, "vsync");
        compare_count(de_o, o.de, "de");
        compare_pos(xpos_o, ypos_o, o.x, o.y);
        if (o.de) begin
            compare_pixel({r_o, g_o, b_o}, o.pix, "pixel");
        end
        if (o.cnt_en) begin
            acc_de = acc_de + de_o;
            acc_hs = acc_hs + !hsync_o;
            acc_vs = acc_vs + !vsync_o;
        end
        if (o.last) begin
            compare_count(acc_de, cfg[o.rec][19], "DE cycles per frame");
            compare_count(acc_hs, cfg[o.rec][20], "HSYNC-low cycles per frame");
            compare_count(acc_vs, cfg[o.rec][21], "VSYNC-low cycles per frame");
            acc_de      = 0;
            acc_hs      = 0;
            acc_vs      = 0;
            frames_done = frames_done + 1;
        end
    endtask

    // Inputs on the low clock phase are those that the next rising edge samples
    always @(negedge PCLK_OUT_i) begin : model
        exp_t   e;
        integer hstart;
        integer vstart;
        if (!arst_n_i) begin
            m_h   = '0;
            m_v   = '0;
            m_run = 1'b0;
            m_rec = 0;
            exp_q.delete();
        end else begin
            hstart   = h_synclen_i + h_backporch_i;
            vstart   = v_synclen_i + v_backporch_i;
            e.hs     = !(m_h < h_synclen_i);
            e.vs     = !(m_v < v_synclen_i);
            e.de     = (m_h >= hstart) && (m_h < hstart + h_active_i) &&
                       (m_v >= vstart) && (m_v < vstart + v_active_i);
            e.x      = e.de ? m_h - hstart : '0;
            e.y      = e.de ? m_v - vstart : '0;
            e.pix    = expect_pixel(e.x, e.y, {ext_r_i, ext_g_i, ext_b_i});
            e.cnt_en = m_run;
            e.last   = m_run && (frame_start_i ||
                       (m_h == h_total_i - 1 && m_v == v_total_i - 1));
            e.rec    = m_rec;
            exp_q.push_back(e);
            if (exp_q.size() > PIPE_LATENCY) begin
                check_output(exp_q.pop_front());
            end
            if (frame_start_i) begin
                m_rec = m_run ? m_rec + 1 : 0;
                m_run = 1'b1;
                m_h   = '0;
                m_v   = '0;
            end else if (m_h == h_total_i - 1) begin
                m_h = '0;
                m_v = (m_v == v_total_i - 1) ? '0 : m_v + 1'b1;
            end else begin
                m_h = m_h + 1'b1;
            end
        end
    end

    always @(posedge PCLK_OUT_i) begin : pixel_drive
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        take_byte(r);
        take_byte(g);
        take_byte(b);
        ext_r_i <= r;
        ext_g_i <= g;
        ext_b_i <= b;
    end

    always @(posedge PCLK_OUT_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            report_failure("Timeout: the run went past its cycle limit");
        end
    end

    initial begin
        lfsr_state    = 32'h8bd0;
        cycle_cnt     = 0;
        cycle_limit   = 100;
        frames_done   = 0;
        total_frames  = 0;
        acc_de        = 0;
        acc_hs        = 0;
        acc_vs        = 0;
        arst_n_i      = 1'b0;
        frame_start_i = 1'b0;
        ext_r_i       = 8'd0;
        ext_g_i       = 8'd0;
        ext_b_i       = 8'd0;
        load_trace();
        if (n_rec == 0) begin
            report_failure("The trace file holds no test records");
        end
        for (int r = 0; r < n_rec; r++) begin
            total_frames = total_frames + cfg[r][18];
            cycle_limit  = cycle_limit + cfg[r][18] * cfg[r][0] * cfg[r][4];
        end
        apply_config(0);
        repeat (5) @(posedge PCLK_OUT_i);
        arst_n_i <= 1'b1;
        for (int r = 0; r < n_rec; r++) begin
            @(posedge PCLK_OUT_i);
            frame_start_i <= 1'b1;
            @(posedge PCLK_OUT_i);
            frame_start_i <= 1'b0;
            // The new raster takes over together with the restarted counters
            apply_config(r);
            repeat (cfg[r][18] * cfg[r][0] * cfg[r][4] - 2) @(posedge PCLK_OUT_i);
        end
        // Let the last frame drain out of the pipeline
        repeat (PIPE_LATENCY + 3) @(posedge PCLK_OUT_i);
        @(negedge PCLK_OUT_i);
        if (frames_done == total_frames) begin
            $display("Simulation passed");
            $finish;
        end else begin
            report_failure("Not every frame of the trace reached the outputs");
        end
    end

endmodule

// File: verilog/pixel_output.sv
// Last stage which picks test pattern, mask colour or the pixel itself
// The test pattern uses only the low 8 bits of the positions
`timescale 1ns/1ps

module pixel_output
    import scan_pkg::*;
#(
    parameter int H_CNT_W = scan_pkg::H_CNT_W,
    parameter int V_CNT_W = scan_pkg::V_CNT_W
) (
    input  logic                PCLK_OUT_i,
    input  logic                arst_n_i,
    input  logic                testpattern_en_i,
    input  logic [3:0]          mask_br_i,
    input  logic [2:0]          mask_color_i,
    video_stage_if.dst          in_i,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                de_o,
    output logic [H_CNT_W-1:0]  xpos_o,
    output logic [V_CNT_W-1:0]  ypos_o,
    output pixel_t              pix_o
);

    logic [7:0] mask_val;
    logic [7:0] tp_val;
    pixel_t     mask_pix;

    // Mask colour bits are ordered r, g, b from the top
    assign mask_val   = {2{mask_br_i}};
    assign mask_pix.r = mask_color_i[2] ? mask_val : 8'h00;
    assign mask_pix.g = mask_color_i[1] ? mask_val : 8'h00;
    assign mask_pix.b = mask_color_i[0] ? mask_val : 8'h00;

    assign tp_val = in_i.xpos[7:0] ^ in_i.ypos[7:0];

    always_ff @(posedge PCLK_OUT_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
            de_o    <= 1'b0;
            xpos_o  <= '0;
            ypos_o  <= '0;
            pix_o   <= '0;
        end else begin
            hsync_o <= in_i.hsync;
            vsync_o <= in_i.vsync;
            de_o    <= in_i.de;
            xpos_o  <= in_i.xpos;
            ypos_o  <= in_i.ypos;
            if (testpattern_en_i) begin
                pix_o <= {3{tp_val}};
            end else if (in_i.outside) begin
                pix_o <= mask_pix;
            end else begin
                pix_o <= in_i.pix;
            end
        end
    end

endmodule

// File: verilog/scan_pkg.sv
// Shared types and constants for the output pixel pipeline
// Counter widths bound the largest raster that the timing generator can run
package scan_pkg;

    // One RGB pixel with red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // Horizontal and vertical counter widths
    parameter int H_CNT_W = 12;
    parameter int V_CNT_W = 11;

    typedef logic [H_CNT_W-1:0] hcnt_t;
    typedef logic [V_CNT_W-1:0] vcnt_t;

    // Scanline row pattern length and the phase that walks through it
    parameter int SL_ROWS = 6;
    typedef logic [2:0] sl_phase_t;

    // Strength code where 0 darkens the least
    typedef logic [3:0] sl_str_t;

    // Register stages from counter state to the outputs
    // Stage 1 timing, stage 2 window, stages 3-4 scanlines, stage 5 output select
    parameter int PIPE_LATENCY = 5;

endpackage

// File: verilog/scanconverter.sv
// Output half of the scan converter with the external RGB input as its only source
// Configuration inputs are levels that must not change inside a frame
`timescale 1ns/1ps

module scanconverter
    import scan_pkg::*;
#(
    parameter int H_CNT_W = scan_pkg::H_CNT_W,
    parameter int V_CNT_W = scan_pkg::V_CNT_W,
    parameter int SL_ROWS = scan_pkg::SL_ROWS
) (
    input  logic                  PCLK_OUT_i,
    input  logic                  arst_n_i,
    input  logic                  frame_start_i,
    input  logic [7:0]            ext_r_i,
    input  logic [7:0]            ext_g_i,
    input  logic [7:0]            ext_b_i,
    input  logic [H_CNT_W-1:0]    h_total_i,
    input  logic [H_CNT_W-1:0]    h_active_i,
    input  logic [H_CNT_W-1:0]    h_synclen_i,
    input  logic [H_CNT_W-1:0]    h_backporch_i,
    input  logic [V_CNT_W-1:0]    v_total_i,
    input  logic [V_CNT_W-1:0]    v_active_i,
    input  logic [V_CNT_W-1:0]    v_synclen_i,
    input  logic [V_CNT_W-1:0]    v_backporch_i,
    input  logic [H_CNT_W-1:0]    x_offset_i,
    input  logic [H_CNT_W-1:0]    x_size_i,
    input  logic [V_CNT_W-1:0]    y_offset_i,
    input  logic [V_CNT_W-1:0]    y_size_i,
    input  sl_phase_t             sl_period_i,
    input  logic [SL_ROWS-1:0]    sl_overlay_i,
    input  sl_str_t [SL_ROWS-1:0] sl_strength_i,
    input  logic                  testpattern_en_i,
    input  logic [3:0]            mask_br_i,
    input  logic [2:0]            mask_color_i,
    output logic [7:0]            r_o,
    output logic [7:0]            g_o,
    output logic [7:0]            b_o,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  de_o,
    output logic [H_CNT_W-1:0]    xpos_o,
    output logic [V_CNT_W-1:0]    ypos_o
);

    pixel_t ext_pix;
    pixel_t out_pix;

    video_stage_if #(.H_CNT_W(H_CNT_W), .V_CNT_W(V_CNT_W)) tg_if ();
    video_stage_if #(.H_CNT_W(H_CNT_W), .V_CNT_W(V_CNT_W)) wm_if ();
    video_stage_if #(.H_CNT_W(H_CNT_W), .V_CNT_W(V_CNT_W)) sl_if ();

    assign ext_pix.r = ext_r_i;
    assign ext_pix.g = ext_g_i;
    assign ext_pix.b = ext_b_i;

    timing_gen #(.H_CNT_W(H_CNT_W), .V_CNT_W(V_CNT_W), .SL_ROWS(SL_ROWS)) timing_gen_i (
        .*,
        .ext_pix_i (ext_pix),
        .out_o     (tg_if.src)
    );

    window_mask #(.H_CNT_W(H_CNT_W), .V_CNT_W(V_CNT_W)) window_mask_i (
        .*,
        .in_i  (tg_if.dst),
        .out_o (wm_if.src)
    );

    scanline_gen #(.H_CNT_W(H_CNT_W), .V_CNT_W(V_CNT_W), .SL_ROWS(SL_ROWS)) scanline_gen_i (
        .*,
        .in_i  (wm_if.dst),
        .out_o (sl_if.src)
    );

    pixel_output #(.H_CNT_W(H_CNT_W), .V_CNT_W(V_CNT_W)) pixel_output_i (
        .*,
        .in_i  (sl_if.dst),
        .pix_o (out_pix)
    );

    assign r_o = out_pix.r;
    assign g_o = out_pix.g;
    assign b_o = out_pix.b;

    // DE leaves the chain PIPE_LATENCY-1 edges after the timing stage registers it
    a_de_latency: assert property (@(posedge PCLK_OUT_i) disable iff (!arst_n_i)
        de_o == $past(tg_if.de, PIPE_LATENCY - 1));

endmodule

// File: verilog/scanline_gen.sv
// Subtractive scanlines over two stages, selected per line by the row phase
// Each channel is lowered by (code+1)*16-1 and clamps at zero
`timescale 1ns/1ps

module scanline_gen
    import scan_pkg::*;
#(
    parameter int H_CNT_W = scan_pkg::H_CNT_W,
    parameter int V_CNT_W = scan_pkg::V_CNT_W,
    parameter int SL_ROWS = scan_pkg::SL_ROWS
) (
    input  logic                     PCLK_OUT_i,
    input  logic                     arst_n_i,
    input  logic [SL_ROWS-1:0]       sl_overlay_i,
    input  sl_str_t [SL_ROWS-1:0]    sl_strength_i,
    video_stage_if.dst               in_i,
    video_stage_if.src               out_o
);

    logic               a_hsync;
    logic               a_vsync;
    logic               a_de;
    logic [H_CNT_W-1:0] a_xpos;
    logic [V_CNT_W-1:0] a_ypos;
    sl_phase_t          a_phase;
    logic               a_outside;
    logic               a_draw;
    logic [7:0]         a_amount;
    pixel_t             a_pix;

    function automatic logic [7:0] darken(input logic [7:0] ch, input logic [7:0] amount);
        return (ch > amount) ? ch - amount : 8'h00;
    endfunction

    // Stage A looks up whether this row is drawn and how strongly
    always_ff @(posedge PCLK_OUT_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            a_hsync   <= 1'b1;
            a_vsync   <= 1'b1;
            a_de      <= 1'b0;
            a_xpos    <= '0;
            a_ypos    <= '0;
            a_phase   <= '0;
            a_outside <= 1'b0;
            a_draw    <= 1'b0;
        end else begin
            a_hsync   <= in_i.hsync;
            a_vsync   <= in_i.vsync;
            a_de      <= in_i.de;
            a_xpos    <= in_i.xpos;
            a_ypos    <= in_i.ypos;
            a_phase   <= in_i.sl_phase;
            a_outside <= in_i.outside;
            a_draw    <= sl_overlay_i[in_i.sl_phase];
        end
    end

    // (code+1)*16-1 is the code with four ones appended
    always_ff @(posedge PCLK_OUT_i) begin
        a_pix    <= in_i.pix;
        a_amount <= {sl_strength_i[in_i.sl_phase], 4'hf};
    end

    // Stage B applies the darkening
    always_ff @(posedge PCLK_OUT_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_o.hsync    <= 1'b1;
            out_o.vsync    <= 1'b1;
            out_o.de       <= 1'b0;
            out_o.xpos     <= '0;
            out_o.ypos     <= '0;
            out_o.sl_phase <= '0;
            out_o.outside  <= 1'b0;
        end else begin
            out_o.hsync    <= a_hsync;
            out_o.vsync    <= a_vsync;
            out_o.de       <= a_de;
            out_o.xpos     <= a_xpos;
            out_o.ypos     <= a_ypos;
            out_o.sl_phase <= a_phase;
            out_o.outside  <= a_outside;
        end
    end

    always_ff @(posedge PCLK_OUT_i) begin
        if (a_draw) begin
            out_o.pix.r <= darken(a_pix.r, a_amount);
            out_o.pix.g <= darken(a_pix.g, a_amount);
            out_o.pix.b <= darken(a_pix.b, a_amount);
        end else begin
            out_o.pix <= a_pix;
        end
    end

    // The phase comes from the timing generator, which must keep it inside the pattern
    a_draw_phase: assert property (@(posedge PCLK_OUT_i) disable iff (!arst_n_i)
        in_i.sl_phase < SL_ROWS);

endmodule

// File: verilog/timing_gen.sv
// Progressive output timing, restarted by a one-cycle frame_start_i pulse
// Configuration must describe a legal raster and sl_period_i must stay below SL_ROWS
`timescale 1ns/1ps

module timing_gen
    import scan_pkg::*;
#(
    parameter int H_CNT_W = scan_pkg::H_CNT_W,
    parameter int V_CNT_W = scan_pkg::V_CNT_W,
    parameter int SL_ROWS = scan_pkg::SL_ROWS
) (
    input  logic               PCLK_OUT_i,
    input  logic               arst_n_i,
    input  logic               frame_start_i,
    input  logic [H_CNT_W-1:0] h_total_i,
    input  logic [H_CNT_W-1:0] h_active_i,
    input  logic [H_CNT_W-1:0] h_synclen_i,
    input  logic [H_CNT_W-1:0] h_backporch_i,
    input  logic [V_CNT_W-1:0] v_total_i,
    input  logic [V_CNT_W-1:0] v_active_i,
    input  logic [V_CNT_W-1:0] v_synclen_i,
    input  logic [V_CNT_W-1:0] v_backporch_i,
    input  sl_phase_t          sl_period_i,
    input  pixel_t             ext_pix_i,
    video_stage_if.src         out_o
);

    logic [H_CNT_W-1:0] h_cnt;
    logic [H_CNT_W-1:0] h_act_start;
    logic [H_CNT_W-1:0] h_act_end;
    logic [V_CNT_W-1:0] v_cnt;
    logic [V_CNT_W-1:0] v_next;
    logic [V_CNT_W-1:0] v_act_start;
    logic [V_CNT_W-1:0] v_act_end;
    logic               h_in;
    logic               v_in;
    sl_phase_t          sl_phase;

    assign h_act_start = h_synclen_i + h_backporch_i;
    assign h_act_end   = h_act_start + h_active_i;
    assign v_act_start = v_synclen_i + v_backporch_i;
    assign v_act_end   = v_act_start + v_active_i;

    assign h_in   = (h_cnt >= h_act_start) && (h_cnt < h_act_end);
    assign v_in   = (v_cnt >= v_act_start) && (v_cnt < v_act_end);
    assign v_next = (v_cnt == v_total_i - 1'b1) ? '0 : v_cnt + 1'b1;

    // Counters and the scanline row phase, which steps at the end of each active line
    always_ff @(posedge PCLK_OUT_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            h_cnt    <= '0;
            v_cnt    <= '0;
            sl_phase <= '0;
        end else if (frame_start_i) begin
            h_cnt    <= '0;
            v_cnt    <= '0;
            sl_phase <= '0;
        end else if (h_cnt == h_total_i - 1'b1) begin
            h_cnt <= '0;
            v_cnt <= v_next;
            if (v_next == v_act_start) begin
                sl_phase <= '0;
            end else if (v_in) begin
                sl_phase <= (sl_phase == sl_period_i) ? '0 : sl_phase + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Stage 1
    always_ff @(posedge PCLK_OUT_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_o.hsync    <= 1'b1;
            out_o.vsync    <= 1'b1;
            out_o.de       <= 1'b0;
            out_o.xpos     <= '0;
            out_o.ypos     <= '0;
            out_o.sl_phase <= '0;
        end else begin
            out_o.hsync    <= (h_cnt >= h_synclen_i);
            out_o.vsync    <= (v_cnt >= v_synclen_i);
            out_o.de       <= h_in && v_in;
            out_o.xpos     <= (h_in && v_in) ? h_cnt - h_act_start : '0;
            out_o.ypos     <= (h_in && v_in) ? v_cnt - v_act_start : '0;
            out_o.sl_phase <= sl_phase;
        end
    end

    // The external pixel joins the counter state sampled on the same edge
    always_ff @(posedge PCLK_OUT_i) begin
        out_o.pix <= ext_pix_i;
    end

    // The window decision is made by the next stage
    assign out_o.outside = 1'b0;

    a_h_cnt_range: assert property (@(posedge PCLK_OUT_i) disable iff (!arst_n_i)
        h_cnt < h_total_i);

    a_phase_range: assert property (@(posedge PCLK_OUT_i) disable iff (!arst_n_i)
        sl_phase < SL_ROWS);

endmodule

// File: verilog/video_stage_if.sv
// Signals of one pipeline stage, one pixel per clock
// There is no handshake and the receiving stage samples on every edge
`timescale 1ns/1ps

interface video_stage_if
    import scan_pkg::*;
#(
    parameter int H_CNT_W = scan_pkg::H_CNT_W,
    parameter int V_CNT_W = scan_pkg::V_CNT_W
);

    logic               hsync;
    logic               vsync;
    logic               de;
    logic [H_CNT_W-1:0] xpos;
    logic [V_CNT_W-1:0] ypos;
    pixel_t             pix;
    sl_phase_t          sl_phase;
    // Set when the pixel lies outside the visible window
    logic               outside;

    modport src (
        output hsync, vsync, de, xpos, ypos, pix, sl_phase, outside
    );

    modport dst (
        input hsync, vsync, de, xpos, ypos, pix, sl_phase, outside
    );

endinterface

// File: verilog/window_mask.sv
// Marks pixels outside the rectangular visible window
// Offsets are unsigned so the window cannot start left of or above the active area
`timescale 1ns/1ps

module window_mask
    import scan_pkg::*;
#(
    parameter int H_CNT_W = scan_pkg::H_CNT_W,
    parameter int V_CNT_W = scan_pkg::V_CNT_W
) (
    input  logic               PCLK_OUT_i,
    input  logic               arst_n_i,
    input  logic [H_CNT_W-1:0] x_offset_i,
    input  logic [H_CNT_W-1:0] x_size_i,
    input  logic [V_CNT_W-1:0] y_offset_i,
    input  logic [V_CNT_W-1:0] y_size_i,
    video_stage_if.dst         in_i,
    video_stage_if.src         out_o
);

    logic [H_CNT_W:0] x_end;
    logic [V_CNT_W:0] y_end;
    logic             outside_nxt;

    // One extra bit keeps offset plus size from wrapping
    assign x_end = {1'b0, x_offset_i} + {1'b0, x_size_i};
    assign y_end = {1'b0, y_offset_i} + {1'b0, y_size_i};

    assign outside_nxt = (in_i.xpos < x_offset_i) || ({1'b0, in_i.xpos} >= x_end) ||
                         (in_i.ypos < y_offset_i) || ({1'b0, in_i.ypos} >= y_end);

    always_ff @(posedge PCLK_OUT_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_o.hsync    <= 1'b1;
            out_o.vsync    <= 1'b1;
            out_o.de       <= 1'b0;
            out_o.xpos     <= '0;
            out_o.ypos     <= '0;
            out_o.sl_phase <= '0;
            out_o.outside  <= 1'b0;
        end else begin
            out_o.hsync    <= in_i.hsync;
            out_o.vsync    <= in_i.vsync;
            out_o.de       <= in_i.de;
            out_o.xpos     <= in_i.xpos;
            out_o.ypos     <= in_i.ypos;
            out_o.sl_phase <= in_i.sl_phase;
            out_o.outside  <= outside_nxt;
        end
    end

    always_ff @(posedge PCLK_OUT_i) begin
        out_o.pix <= in_i.pix;
    end

endmodule
